// ==== build.f ====
+incdir+.
memPkg.sv
memCtrl.sv
byteRam.sv
ioTxFifo.sv
memSubsystem.sv
tb_memSubsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_memSubsystem
FILELIST  ?= build.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== tb_memSubsystem.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_memSubsystem;

    // all RAM traffic stays in this low window, which includes the I/O alias at 0
    localparam int Window = 256;

    logic             clk;
    logic             rst;
    logic             i_rdy;
    logic             i_fetchEn;
    memPkg::addr_t    i_fetchAddr;
    logic             o_fetchDone;
    memPkg::word_t    o_fetchInst;
    logic             i_dataEn;
    memPkg::dataReq_t i_dataReq;
    logic             o_dataDone;
    memPkg::word_t    o_loadData;
    logic             o_ioValid;
    memPkg::byte_t    o_ioByte;
    logic             i_ioReady;

    memPkg::byte_t refMem [0:(1 << `RAM_AW)-1];
    memPkg::byte_t ioExpQ [$];

    int seed = 2354;
    int rdyRoll = 0;
    int ioRoll = 0;
    int cycleCount = 0;
    int reqCount = 0;
    int checks = 0;
    int mismatches = 0;
    int otherErrors = 0;

    // open request state, one set per port
    logic          dataPending = 0;
    logic          dataIsLoad = 0;
    logic          dataTiming = 0;
    memPkg::word_t dataExp = '0;
    string         dataName = "";
    int            dataLatency = 0;
    int            dataIssueCycle = 0;
    int            dataIssueCount = 0;
    int            dataDoneCount = 0;
    int            dataDoneCycle = 0;
    logic          fetchPending = 0;
    logic          fetchTiming = 0;
    memPkg::word_t fetchExp = '0;
    string         fetchName = "";
    int            fetchIssueCycle = 0;
    int            fetchIssueCount = 0;
    int            fetchDoneCount = 0;
    int            fetchDoneCycle = 0;

    logic stallMode = 0;
    int   ioMode = 2;

    memSubsystem i_memSubsystem (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .i_dataEn    (i_dataEn),
        .i_dataReq   (i_dataReq),
        .o_dataDone  (o_dataDone),
        .o_loadData  (o_loadData),
        .o_ioValid   (o_ioValid),
        .o_ioByte    (o_ioByte),
        .i_ioReady   (i_ioReady)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycleCount++;

    // rolls taken on the falling edge, applied just after the rising edge
    always @(negedge clk) begin
        rdyRoll = $random(seed);
        ioRoll  = $random(seed);
    end

    always @(posedge clk) begin
        #1;
        i_rdy     = !stallMode || (rdyRoll % 3 != 0);
        i_ioReady = (ioMode == 2) || (ioMode == 1 && (ioRoll % 2 != 0));
    end

    // little-endian, zero-extended word from the model
    function automatic memPkg::word_t refRead(input memPkg::addr_t addr, input int len);
        memPkg::word_t word;
        memPkg::addr_t byteAddr;
        word = '0;
        for (int i = 0; i < len; i++) begin
            byteAddr = addr + memPkg::addr_t'(i);
            word[8*i +: 8] = refMem[memPkg::ramIdx_t'(byteAddr)];
        end
        return word;
    endfunction

    function automatic memPkg::byte_t fillByte(input int unsigned a);
        return memPkg::byte_t'((a * 37) ^ (a >> 8) ^ 32'h5c);
    endfunction

    function automatic int unsigned randBelow(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic int pickLen();
        case (randBelow(3))
            0: return 1;
            1: return 2;
            default: return 4;
        endcase
    endfunction

    always @(negedge clk) begin
        if (!rst && o_dataDone === 1'b1) begin
            dataDoneCount++;
            dataDoneCycle = cycleCount;
            checks++;
            if (!dataPending || dataDoneCount != dataIssueCount) begin
                otherErrors++;
                $display("data done pulse at cycle %0d with no open data request", cycleCount);
            end else begin
                if (dataIsLoad && o_loadData !== dataExp) begin
                    mismatches++;
                    $display("Mismatch %s: expected %h, actual %h", dataName, dataExp, o_loadData);
                end
                if (dataTiming && cycleCount - dataIssueCycle != dataLatency) begin
                    mismatches++;
                    $display("Mismatch %s latency: expected %0d, actual %0d",
                             dataName, dataLatency, cycleCount - dataIssueCycle);
                end
            end
        end
        if (!rst && o_fetchDone === 1'b1) begin
            fetchDoneCount++;
            fetchDoneCycle = cycleCount;
            checks++;
            if (!fetchPending || fetchDoneCount != fetchIssueCount) begin
                otherErrors++;
                $display("fetch done pulse at cycle %0d with no open fetch", cycleCount);
            end else begin
                if (o_fetchInst !== fetchExp) begin
                    mismatches++;
                    $display("Mismatch %s: expected %h, actual %h", fetchName, fetchExp, o_fetchInst);
                end
                // fetch is a 4-byte read, done in t+5
                if (fetchTiming && cycleCount - fetchIssueCycle != 5) begin
                    mismatches++;
                    $display("Mismatch %s latency: expected 5, actual %0d",
                             fetchName, cycleCount - fetchIssueCycle);
                end
            end
        end
    end

    // I/O stream, a byte moves on the next rising edge
    always @(negedge clk) begin
        if (!rst && o_ioValid === 1'b1 && i_ioReady === 1'b1) begin
            if (ioExpQ.size() == 0) begin
                otherErrors++;
                $display("I/O byte %h appeared on the stream with none expected", o_ioByte);
            end else begin
                checks++;
                if (o_ioByte !== ioExpQ[0]) begin
                    mismatches++;
                    $display("Mismatch io stream: expected %h, actual %h", ioExpQ[0], o_ioByte);
                end
                void'(ioExpQ.pop_front());
            end
        end
    end

    task automatic dataAccess(input logic store, input int len, input memPkg::addr_t addr,
                              input memPkg::word_t wdata, input string name);
        memPkg::addr_t byteAddr;
        @(posedge clk);
        #1;
        dataExp = '0;
        if (store) begin
            for (int i = 0; i < len; i++) begin
                byteAddr = addr + memPkg::addr_t'(i);
                if (byteAddr == `IO_ADDR) begin
                    ioExpQ.push_back(wdata[8*i +: 8]);
                end else begin
                    refMem[memPkg::ramIdx_t'(byteAddr)] = wdata[8*i +: 8];
                end
            end
        end else begin
            dataExp = refRead(addr, len);
        end
        dataName       = name;
        dataIsLoad     = !store;
        dataLatency    = store ? len : len + 1;
        dataIssueCycle = cycleCount;
        reqCount++;
        dataIssueCount++;
        dataPending     = 1'b1;
        i_dataReq.store = store;
        i_dataReq.len   = memPkg::len_t'(len);
        i_dataReq.addr  = addr;
        i_dataReq.wdata = wdata;
        i_dataEn        = 1'b1;
        while (dataDoneCount != dataIssueCount) @(posedge clk);
        #1;
        i_dataEn    = 1'b0;
        dataPending = 1'b0;
    endtask

    task automatic fetchAccess(input memPkg::addr_t addr, input string name);
        @(posedge clk);
        #1;
        fetchExp        = refRead(addr, 4);
        fetchName       = name;
        fetchIssueCycle = cycleCount;
        reqCount++;
        fetchIssueCount++;
        fetchPending = 1'b1;
        i_fetchAddr  = addr;
        i_fetchEn    = 1'b1;
        while (fetchDoneCount != fetchIssueCount) @(posedge clk);
        #1;
        i_fetchEn    = 1'b0;
        fetchPending = 1'b0;
    endtask

    task automatic finishRun();
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        while (cycleCount < 40 * reqCount + 2000) @(posedge clk);
        otherErrors++;
        $display("timeout after %0d cycles with %0d requests issued", cycleCount, reqCount);
        finishRun();
    end

    initial begin
        memPkg::word_t wd;
        int unsigned   a;
        int unsigned   fa;
        int            len;
        clk         = 1'b0;
        rst         = 1'b1;
        i_rdy       = 1'b1;
        i_fetchEn   = 1'b0;
        i_fetchAddr = '0;
        i_dataEn    = 1'b0;
        i_dataReq   = '0;
        i_ioReady   = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        checks++;
        if (o_dataDone !== 1'b0 || o_fetchDone !== 1'b0 || o_ioValid !== 1'b0) begin
            otherErrors++;
            $display("done or I/O valid not low after reset");
        end

        // known pattern in the window so untouched bytes can be checked
        dataTiming  = 1'b1;
        fetchTiming = 1'b1;
        for (int unsigned p = 0; p < Window; p += 4) begin
            wd = {fillByte(p + 3), fillByte(p + 2), fillByte(p + 1), fillByte(p)};
            dataAccess(1'b1, 4, p, wd, "prefill");
        end

        repeat (12) begin
            len = pickLen();
            a   = 2 + randBelow(Window - 6);
            dataAccess(1'b1, len, a, $random(seed), "store");
            dataAccess(1'b0, 1, a, '0, "load len 1");
            dataAccess(1'b0, 2, a, '0, "load len 2");
            dataAccess(1'b0, 4, a, '0, "load len 4");
            dataAccess(1'b0, 4, a - 2, '0, "neighbour load");
        end

        repeat (6) begin
            a = randBelow(Window - 4);
            dataAccess(1'b1, 4, a, $random(seed), "store for fetch");
            fetchAccess(a, "fetch");
        end

        // same-cycle requests, address ranges kept apart
        fetchTiming = 1'b0;
        for (int k = 0; k < 4; k++) begin
            a   = Window / 2 + randBelow(Window / 2 - 4);
            fa  = randBelow(Window / 2 - 4);
            wd  = $random(seed);
            len = pickLen();
            fork
                dataAccess((k % 2) == 0, len, a, wd, "contention data");
                fetchAccess(fa, "contention fetch");
            join
            checks++;
            if (dataDoneCycle >= fetchDoneCycle) begin
                otherErrors++;
                $display("fetch finished before the data request under contention");
            end
        end

        stallMode  = 1'b1;
        dataTiming = 1'b0;
        repeat (30) begin
            a = randBelow(Window - 4);
            case (randBelow(3))
                0: dataAccess(1'b1, pickLen(), a, $random(seed), "stalled store");
                1: dataAccess(1'b0, pickLen(), a, '0, "stalled load");
                default: fetchAccess(a, "stalled fetch");
            endcase
        end
        stallMode   = 1'b0;
        fetchTiming = 1'b1;

        // fill the tx FIFO with the stream held off
        ioMode     = 0;
        dataTiming = 1'b1;
        repeat (`IO_FIFO_DEPTH) dataAccess(1'b1, 1, `IO_ADDR, $random(seed), "io store");
        a = 64 + randBelow(64);
        dataAccess(1'b1, 4, a, $random(seed), "store with full fifo");
        dataAccess(1'b0, 4, a, '0, "load with full fifo");
        dataTiming = 1'b0;
        fork
            dataAccess(1'b1, 1, `IO_ADDR, $random(seed), "io store blocked");
            begin
                repeat (12) @(posedge clk);
                checks++;
                if (dataDoneCount == dataIssueCount) begin
                    otherErrors++;
                    $display("I/O store completed while the FIFO was full");
                end
                #1 ioMode = 1;
            end
        join
        stallMode = 1'b1;
        repeat (10) dataAccess(1'b1, 1, `IO_ADDR, $random(seed), "io store toggled");
        while (ioExpQ.size() != 0) @(posedge clk);
        stallMode = 1'b0;
        ioMode    = 2;
        // low alias of the I/O address
        dataAccess(1'b0, 4, 0, '0, "io alias load");
        repeat (4) @(posedge clk);
        checks++;
        if (o_ioValid !== 1'b0) begin
            otherErrors++;
            $display("I/O stream still valid after every expected byte was delivered");
        end
        finishRun();
    end

endmodule

// ==== memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_rdy,
    // instruction fetch port
    input  logic             i_fetchEn,
    input  memPkg::addr_t    i_fetchAddr,
    output logic             o_fetchDone,
    output memPkg::word_t    o_fetchInst,
    // data port
    input  logic             i_dataEn,
    input  memPkg::dataReq_t i_dataReq,
    output logic             o_dataDone,
    output memPkg::word_t    o_loadData,
    // I/O byte stream
    output logic             o_ioValid,
    output memPkg::byte_t    o_ioByte,
    input  logic             i_ioReady
);

    memPkg::ramAcc_t ramAcc;
    memPkg::byte_t   ramRdata;
    logic            ioPush;
    memPkg::byte_t   ioPushByte;
    logic            ioFull;

    memCtrl i_memCtrl (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_dataEn    (i_dataEn),
        .i_dataReq   (i_dataReq),
        .i_ramRdata  (ramRdata),
        .i_ioFull    (ioFull),
        .o_ram       (ramAcc),
        .o_ioPush    (ioPush),
        .o_ioByte    (ioPushByte),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dataDone  (o_dataDone),
        .o_loadData  (o_loadData)
    );

    byteRam i_byteRam (
        .clk     (clk),
        .i_acc   (ramAcc),
        .o_rdata (ramRdata)
    );

    ioTxFifo i_ioTxFifo (
        .clk        (clk),
        .rst        (rst),
        .i_push     (ioPush),
        .i_pushByte (ioPushByte),
        .i_ioReady  (i_ioReady),
        .o_full     (ioFull),
        .o_ioValid  (o_ioValid),
        .o_ioByte   (o_ioByte)
    );

endmodule

// ==== ioTxFifo.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module ioTxFifo (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_push,
    input  memPkg::byte_t i_pushByte,
    input  logic          i_ioReady,
    output logic          o_full,
    output logic          o_ioValid,
    output memPkg::byte_t o_ioByte
);

    localparam int Depth = `IO_FIFO_DEPTH;
    localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW  = $clog2(Depth + 1);

    memPkg::byte_t   fifoMem [0:Depth-1];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            doPush;
    logic            doPop;

    // wrap explicitly, depth need not be a power of two
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(Depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_full    = (count == CntW'(Depth));
    assign o_ioValid = (count != '0);
    assign o_ioByte  = fifoMem[rdPtr];

    assign doPush = i_push && !o_full;
    assign doPop  = o_ioValid && i_ioReady;

    always_ff @(posedge clk) begin
        if (doPush) begin
            fifoMem[wrPtr] <= i_pushByte;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // push and pop together leave the count alone
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    countInRange: assert property (@(posedge clk) disable iff (rst)
        count <= CntW'(Depth))
        else $error("I/O FIFO count above depth");

endmodule

// ==== byteRam.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module byteRam (
    input  logic            clk,
    input  memPkg::ramAcc_t i_acc,
    output memPkg::byte_t   o_rdata
);

    localparam int Depth = 1 << `RAM_AW;

    memPkg::byte_t mem [0:Depth-1];

    // write port
    always_ff @(posedge clk) begin
        if (i_acc.en && i_acc.we) begin
            mem[i_acc.addr] <= i_acc.wdata;
        end
    end

    // registered read, holds while idle or writing
    always_ff @(posedge clk) begin
        if (i_acc.en && !i_acc.we) begin
            o_rdata <= mem[i_acc.addr];
        end
    end

endmodule

// ==== memCtrl.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module memCtrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_rdy,
    input  logic              i_fetchEn,
    input  memPkg::addr_t     i_fetchAddr,
    input  logic              i_dataEn,
    input  memPkg::dataReq_t  i_dataReq,
    input  memPkg::byte_t     i_ramRdata,
    input  logic              i_ioFull,
    output memPkg::ramAcc_t   o_ram,
    output logic              o_ioPush,
    output memPkg::byte_t     o_ioByte,
    output logic              o_fetchDone,
    output memPkg::word_t     o_fetchInst,
    output logic              o_dataDone,
    output memPkg::word_t     o_loadData
);

    localparam int WordBytes = `WORD_W / `BYTE_W;

    memPkg::ctrlState_t state;
    memPkg::len_t       stage;
    memPkg::len_t       lenReg;
    memPkg::addr_t      addrReg;
    memPkg::word_t      storeWord;
    memPkg::word_t      asmWord;

    memPkg::addr_t      curAddr;
    memPkg::word_t      fullWord;
    memPkg::word_t      readWord;
    logic               readJob;
    logic               issueRead;
    logic               readDone;
    logic               isStore;
    logic               lastStore;
    logic               isIo;
    logic               ioStall;
    logic               advance;

    // byte address of the current stage
    assign curAddr = addrReg + memPkg::addr_t'(stage);
    assign isIo    = (curAddr == `IO_ADDR);

    assign readJob   = (state == memPkg::FETCH) || (state == memPkg::LOAD);
    assign issueRead = readJob && (stage != lenReg);
    assign readDone  = readJob && (stage == lenReg);
    assign isStore   = (state == memPkg::STORE);
    assign lastStore = isStore && (stage == lenReg - 3'd1);

    // freeze on core stall or a full tx buffer under an I/O byte
    assign ioStall = isStore && isIo && i_ioFull;
    assign advance = i_rdy && !ioStall;

    // new byte enters at the top and earlier bytes move down
    assign fullWord = {i_ramRdata, asmWord[`WORD_W-1:`BYTE_W]};
    // dropping the unused low bytes also zero-extends
    assign readWord = fullWord >> (`BYTE_W * (WordBytes - int'(lenReg)));

    always_comb begin
        o_ram.en    = advance && (issueRead || (isStore && !isIo));
        o_ram.we    = isStore;
        o_ram.addr  = curAddr[`RAM_AW-1:0];
        o_ram.wdata = storeWord[`BYTE_W-1:0];
    end

    assign o_ioPush = advance && isStore && isIo;
    assign o_ioByte = storeWord[`BYTE_W-1:0];

    assign o_fetchDone = advance && readDone && (state == memPkg::FETCH);
    assign o_dataDone  = advance && ((readDone && (state == memPkg::LOAD)) || lastStore);
    assign o_fetchInst = readWord;
    assign o_loadData  = readWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::IDLE;
            stage <= '0;
        end else if (advance) begin
            case (state)
                memPkg::IDLE: begin
                    stage <= '0;
                    // data port first
                    if (i_dataEn) begin
                        state <= i_dataReq.store ? memPkg::STORE : memPkg::LOAD;
                    end else if (i_fetchEn) begin
                        state <= memPkg::FETCH;
                    end
                end
                memPkg::FETCH,
                memPkg::LOAD: begin
                    if (readDone) begin
                        state <= memPkg::IDLE;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                memPkg::STORE: begin
                    if (lastStore) begin
                        state <= memPkg::IDLE;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                default: begin
                    state <= memPkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (state == memPkg::IDLE) begin
                if (i_dataEn) begin
                    addrReg   <= i_dataReq.addr;
                    lenReg    <= i_dataReq.len;
                    storeWord <= i_dataReq.wdata;
                end else if (i_fetchEn) begin
                    addrReg <= i_fetchAddr;
                    lenReg  <= memPkg::len_t'(WordBytes);
                end
            end else if (isStore) begin
                // next store byte to the bottom
                storeWord <= storeWord >> `BYTE_W;
            end else if (issueRead && stage != '0) begin
                // byte issued in the last advancing cycle and held by the RAM across stalls
                asmWord <= fullWord;
            end
        end
    end

    // a done pulse lasts one cycle and the job ends with it
    donePulse: assert property (@(posedge clk) disable iff (rst)
        (o_fetchDone || o_dataDone) |=>
            !o_fetchDone && !o_dataDone && (state == memPkg::IDLE))
        else $error("done held for more than one cycle");

    // a store byte for a full I/O FIFO waits in place
    ioStallHolds: assert property (@(posedge clk) disable iff (rst)
        ioStall |=> isStore && (stage == $past(stage)) && (storeWord == $past(storeWord)))
        else $error("store moved on while the I/O FIFO was full");

endmodule

// ==== memPkg.sv ====
`include "mem_defs.svh"

package memPkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`BYTE_W-1:0] byte_t;
    typedef logic [`LEN_W-1:0] len_t;

    // RAM index, the low part of a byte address
    typedef logic [`RAM_AW-1:0] ramIdx_t;

    // data port request, store high means write
    typedef struct packed {
        logic  store;
        len_t  len;
        addr_t addr;
        word_t wdata;
    } dataReq_t;

    // one byte access from the controller to the RAM
    typedef struct packed {
        logic    en;
        logic    we;
        ramIdx_t addr;
        byte_t   wdata;
    } ramAcc_t;

    // current controller job
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        LOAD,
        STORE
    } ctrlState_t;

endpackage

// ==== mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// bus widths
`define ADDR_W 32
`define WORD_W 32
`define BYTE_W 8

// access length in bytes, holds 1, 2 or 4
`define LEN_W 3

// 64 KiB of RAM, low address bits only
`define RAM_AW 16

// byte stores here go to the transmit FIFO
`define IO_ADDR 32'h0003_0000

`define IO_FIFO_DEPTH 4

`endif
